// File: vlog.f
rv_pkg.sv
instr_ctl.sv
imm_gen.sv
reg_file.sv
exec_unit.sv
rv_core.sv
tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_rv_core -f vlog.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int clk_period = 10;
    localparam int n_instr    = 2000;
    localparam int timeout_ns = (n_instr + 2 + 50) * clk_period;

    logic            clk = 1'b0;
    logic            rst_n;
    logic [31:0]     imem_addr;
    logic [31:0]     imem_data;
    logic [31:0]     dmem_addr;
    logic [31:0]     dmem_wdata;
    logic            dmem_we;
    logic [31:0]     dmem_rdata;
    rv_pkg::retire_t retire;

    // Memories seen by the DUT
    logic [31:0] imem [256];
    logic [31:0] dmem_arr [256];
    logic        wr_pend = 1'b0;
    logic [7:0]  wr_idx;
    logic [31:0] wr_data;

    // ISA model state
    logic [31:0] ref_pc;
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [256];

    logic [31:0] lfsr = 32'hf2e6_1027;
    int          errors  = 0;
    int          checked = 0;

    rv_core UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .retire     (retire)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("[FAIL] %s expected %h got %h", name, exp, act);
        errors++;
    endtask

    task automatic report_problem(string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic build_program();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [12:0] off;
        logic [20:0] joff;
        logic [6:0]  op;
        for (int i = 0; i < 256; i++) begin
            kind  = 4'(rand_bits(4));
            // Word 0 is a store, seen by the core while reset is held
            if (i == 0) begin
                kind = 4'd13;
            end
            // Registers x0 to x7 only, to make equal branch operands common
            rd    = 5'(rand_bits(3));
            rs1   = 5'(rand_bits(3));
            rs2   = 5'(rand_bits(3));
            f3    = 3'(rand_bits(3));
            imm12 = 12'(rand_bits(12));
            case (kind)
                4'd6: imem[i] = {20'(rand_bits(20)), rd, 7'h37};
                4'd7: imem[i] = {20'(rand_bits(20)), rd, 7'h17};
                4'd8, 4'd9: begin
                    if (f3[2:1] == 2'b01) begin
                        f3 = f3 ^ 3'b010;
                    end
                    off     = {5'b0, 6'(rand_bits(6)), 2'b00} + 13'd4;
                    imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
                end
                4'd10: begin
                    joff    = {13'b0, 6'(rand_bits(6)), 2'b00} + 21'd4;
                    imem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
                end
                4'd11: imem[i] = {imm12, rs1, 3'b000, rd, 7'h67};
                4'd12: imem[i] = {2'b00, 8'(rand_bits(8)), 2'b00, 5'd0, 3'b010, rd, 7'h03};
                4'd13, 4'd14: begin
                    imm12   = {2'b00, 8'(rand_bits(8)), 2'b00};
                    imem[i] = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], 7'h23};
                end
                4'd15: begin
                    case (2'(rand_bits(2)))
                        2'd0:    op = 7'h33;
                        2'd1:    op = 7'h73;
                        2'd2:    op = 7'h0f;
                        default: op = 7'h5b;
                    endcase
                    imem[i] = {25'(rand_bits(25)), op};
                end
                default: begin
                    if (f3 == 3'b001) begin
                        imm12[11:5] = 7'b0;
                    end else if (f3 == 3'b101) begin
                        imm12[11:5] = {1'b0, imm12[10], 5'b0};
                    end
                    imem[i] = {imm12, rs1, f3, rd, 7'h13};
                end
            endcase
        end
        for (int i = 0; i < 256; i++) begin
            ref_mem[i]  = rand_bits(32);
            dmem_arr[i] = ref_mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc = '0;
    endtask

    task automatic check_retire();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] nxt;
        logic [2:0]  f3;
        logic        wen;
        logic        we;
        logic        taken;
        ins   = imem[ref_pc[9:2]];
        f3    = ins[14:12];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        wen   = 1'b0;
        we    = 1'b0;
        taken = 1'b0;
        res   = '0;
        addr  = '0;
        nxt   = ref_pc + 32'd4;
        case (ins[6:0])
            7'h37: begin
                wen = 1'b1;
                res = {ins[31:12], 12'h000};
            end
            7'h17: begin
                wen = 1'b1;
                res = ref_pc + {ins[31:12], 12'h000};
            end
            7'h6f: begin
                wen = 1'b1;
                res = ref_pc + 32'd4;
                nxt = (ref_pc + imm_j) & ~32'd3;
            end
            7'h67: begin
                if (f3 == 3'b000) begin
                    wen = 1'b1;
                    res = ref_pc + 32'd4;
                    nxt = (a + imm_i) & ~32'd3;
                end
            end
            7'h63: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = !($signed(a) < $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = !(a < b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    nxt = (ref_pc + imm_b) & ~32'd3;
                end
            end
            7'h03: begin
                if (f3 == 3'b010) begin
                    wen  = 1'b1;
                    addr = (a + imm_i) & ~32'd3;
                    res  = ref_mem[addr[9:2]];
                end
            end
            7'h23: begin
                if (f3 == 3'b010) begin
                    we   = 1'b1;
                    addr = (a + imm_s) & ~32'd3;
                end
            end
            7'h13: begin
                wen = 1'b1;
                case (f3)
                    3'd0: res = a + imm_i;
                    3'd1: res = a << ins[24:20];
                    3'd2: res = {31'b0, $signed(a) < $signed(imm_i)};
                    3'd3: res = {31'b0, a < imm_i};
                    3'd4: res = a ^ imm_i;
                    3'd6: res = a | imm_i;
                    3'd7: res = a & imm_i;
                    default: begin
                        if (ins[30]) begin
                            res = $unsigned($signed(a) >>> ins[24:20]);
                        end else begin
                            res = a >> ins[24:20];
                        end
                    end
                endcase
            end
            default: ;
        endcase
        checked++;
        assert (retire.valid === 1'b1)
            else report_problem("retire.valid is low after reset was released");
        assert (retire.pc === ref_pc) else report_mismatch("retire.pc", ref_pc, retire.pc);
        assert (imem_addr === ref_pc) else report_mismatch("imem_addr", ref_pc, imem_addr);
        assert (retire.reg_wen === wen)
            else report_mismatch("retire.reg_wen", 32'(wen), 32'(retire.reg_wen));
        if (wen) begin
            assert (retire.rd === ins[11:7])
                else report_mismatch("retire.rd", 32'(ins[11:7]), 32'(retire.rd));
            assert (retire.wb_data === res)
                else report_mismatch("retire.wb_data", res, retire.wb_data);
        end
        assert (dmem_we === we) else report_mismatch("dmem_we", 32'(we), 32'(dmem_we));
        if (we) begin
            assert (dmem_addr === addr) else report_mismatch("dmem_addr", addr, dmem_addr);
            assert (dmem_wdata === b) else report_mismatch("dmem_wdata", b, dmem_wdata);
            ref_mem[addr[9:2]] = b;
        end
        // Memory side effect lands at the next rising edge
        if (dmem_we === 1'b1) begin
            wr_pend = 1'b1;
            wr_idx  = dmem_addr[9:2];
            wr_data = dmem_wdata;
        end
        if (wen && ins[11:7] != 5'd0) begin
            ref_regs[ins[11:7]] = res;
        end
        ref_pc = nxt;
    endtask

    always @(posedge clk) begin
        if (wr_pend) begin
            dmem_arr[wr_idx] = wr_data;
            wr_pend          = 1'b0;
        end
    end

    // Memory read ports refresh 1 ns after an edge or an address move
    initial begin
        imem_data  = '0;
        dmem_rdata = '0;
        forever begin
            @(posedge clk or imem_addr or dmem_addr);
            #1;
            imem_data  = imem[imem_addr[9:2]];
            dmem_rdata = dmem_arr[dmem_addr[9:2]];
        end
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired before all instructions were checked");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        @(negedge clk);
        assert (retire.valid === 1'b0 && dmem_we === 1'b0)
            else report_problem("retire.valid or dmem_we is high during reset");
        @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (n_instr) begin
            @(negedge clk);
            check_retire();
        end
        $display("Instructions checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    output logic [rv_pkg::xlen-1:0]      imem_addr,
    input  wire logic [rv_pkg::xlen-1:0] imem_data,
    output logic [rv_pkg::xlen-1:0]      dmem_addr,
    output logic [rv_pkg::xlen-1:0]      dmem_wdata,
    output logic                         dmem_we,
    input  wire logic [rv_pkg::xlen-1:0] dmem_rdata,
    output rv_pkg::retire_t              retire
);

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [rv_pkg::xlen-1:0] pc_next;
    rv_pkg::ctl_t            ctl;
    logic                    pc_sel;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] rs1_data;
    logic [rv_pkg::xlen-1:0] rs2_data;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic                    br_eq;
    logic                    br_lt;
    logic [rv_pkg::xlen-1:0] wb_data;
    logic                    reg_wen;

    instr_ctl u_instr_ctl (
        .instruction (imem_data),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .ctl         (ctl),
        .pc_sel      (pc_sel)
    );

    imm_gen u_imm_gen (
        .instruction (imem_data),
        .imm_sel     (ctl.imm_sel),
        .imm         (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (imem_data[19:15]),
        .rs2_addr (imem_data[24:20]),
        .rd_addr  (imem_data[11:7]),
        .wen      (reg_wen),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exec_unit (
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .imm        (imm),
        .a_sel      (ctl.a_sel),
        .b_sel      (ctl.b_sel),
        .alu_op     (ctl.alu_op),
        .br_un      (ctl.br_un),
        .alu_result (alu_result),
        .br_eq      (br_eq),
        .br_lt      (br_lt)
    );

    assign pc_plus4 = pc + 32'd4;
    // Jump and branch targets come out of the ALU, forced word aligned
    assign pc_next  = pc_sel ? {alu_result[31:2], 2'b00} : pc_plus4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    always_comb begin
        case (ctl.wb_sel)
            rv_pkg::wb_mem: wb_data = dmem_rdata;
            rv_pkg::wb_alu: wb_data = alu_result;
            rv_pkg::wb_pc4: wb_data = pc_plus4;
            default:        wb_data = '0;
        endcase
    end

    assign reg_wen    = ctl.reg_wen & rst_n;
    assign imem_addr  = pc;
    assign dmem_addr  = {alu_result[31:2], 2'b00};
    assign dmem_wdata = rs2_data;
    assign dmem_we    = ctl.mem_wr & rst_n;

    assign retire.valid   = rst_n;
    assign retire.pc      = pc;
    assign retire.reg_wen = reg_wen;
    assign retire.rd      = imem_data[11:7];
    assign retire.wb_data = wb_data;

    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("rv_core: PC not word aligned");

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic [rv_pkg::xlen-1:0] rs1_data,
    input  wire logic [rv_pkg::xlen-1:0] rs2_data,
    input  wire logic [rv_pkg::xlen-1:0] pc,
    input  wire logic [rv_pkg::xlen-1:0] imm,
    input  wire logic                    a_sel,
    input  wire logic                    b_sel,
    input  wire rv_pkg::alu_op_e         alu_op,
    input  wire logic                    br_un,
    output logic [rv_pkg::xlen-1:0]      alu_result,
    output logic                         br_eq,
    output logic                         br_lt
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [4:0]              shamt;

    assign op_a  = a_sel ? pc : rs1_data;
    assign op_b  = b_sel ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add:    alu_result = op_a + op_b;
            rv_pkg::alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   alu_result = {31'b0, op_a < op_b};
            rv_pkg::alu_xor:    alu_result = op_a ^ op_b;
            rv_pkg::alu_or:     alu_result = op_a | op_b;
            rv_pkg::alu_and:    alu_result = op_a & op_b;
            rv_pkg::alu_sll:    alu_result = op_a << shamt;
            rv_pkg::alu_srl:    alu_result = op_a >> shamt;
            rv_pkg::alu_sra:    alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::alu_pass_b: alu_result = op_b;
            default:            alu_result = '0;
        endcase
    end

    // Branch comparator always looks at the register operands
    assign br_eq = (rs1_data == rs2_data);
    assign br_lt = br_un ? (rs1_data < rs2_data) : ($signed(rs1_data) < $signed(rs2_data));

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rd_addr,
    input  wire logic                          wen,
    input  wire logic [rv_pkg::xlen-1:0]       rd_data,
    output logic [rv_pkg::xlen-1:0]            rs1_data,
    output logic [rv_pkg::xlen-1:0]            rs2_data
);

    // x0 has no storage
    logic [rv_pkg::xlen-1:0] regs [31:1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    assert property (@(posedge clk)
        ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)))
        else $error("reg_file: x0 read back nonzero");

endmodule

`default_nettype wire

// File: imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire logic [31:0]      instruction,
    input  wire rv_pkg::imm_sel_e imm_sel,
    output logic [31:0]           imm
);

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (imm_sel)
            rv_pkg::imm_i: imm = {{20{sign}}, instruction[31:20]};
            rv_pkg::imm_s: imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            rv_pkg::imm_b: begin
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            rv_pkg::imm_u: imm = {instruction[31:12], 12'b0};
            rv_pkg::imm_j: begin
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: instr_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module instr_ctl (
    input  wire logic [31:0] instruction,
    input  wire logic        br_eq,
    input  wire logic        br_lt,
    output rv_pkg::ctl_t     ctl,
    output logic             pc_sel
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b30;

    assign opcode     = instruction[6:0];
    assign funct3     = instruction[14:12];
    assign funct7_b30 = instruction[30];

    always_comb begin
        // Inactive word, also used for anything not decoded below
        ctl.a_sel   = 1'b0;
        ctl.b_sel   = 1'b1;
        ctl.alu_op  = rv_pkg::alu_add;
        ctl.mem_wr  = 1'b0;
        ctl.reg_wen = 1'b0;
        ctl.imm_sel = rv_pkg::imm_i;
        ctl.br_un   = 1'b0;
        ctl.wb_sel  = rv_pkg::wb_alu;
        case (opcode)
            rv_pkg::opc_lui: begin
                ctl.alu_op  = rv_pkg::alu_pass_b;
                ctl.imm_sel = rv_pkg::imm_u;
                ctl.reg_wen = 1'b1;
            end
            rv_pkg::opc_auipc: begin
                ctl.a_sel   = 1'b1;
                ctl.imm_sel = rv_pkg::imm_u;
                ctl.reg_wen = 1'b1;
            end
            rv_pkg::opc_jal: begin
                ctl.a_sel   = 1'b1;
                ctl.imm_sel = rv_pkg::imm_j;
                ctl.reg_wen = 1'b1;
                ctl.wb_sel  = rv_pkg::wb_pc4;
            end
            rv_pkg::opc_jalr: begin
                if (funct3 == 3'b000) begin
                    ctl.reg_wen = 1'b1;
                    ctl.wb_sel  = rv_pkg::wb_pc4;
                end
            end
            rv_pkg::opc_branch: begin
                // funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01) begin
                    ctl.a_sel   = 1'b1;
                    ctl.imm_sel = rv_pkg::imm_b;
                    ctl.br_un   = funct3[1];
                end
            end
            rv_pkg::opc_load: begin
                if (funct3 == 3'b010) begin
                    ctl.reg_wen = 1'b1;
                    ctl.wb_sel  = rv_pkg::wb_mem;
                end
            end
            rv_pkg::opc_store: begin
                if (funct3 == 3'b010) begin
                    ctl.mem_wr  = 1'b1;
                    ctl.imm_sel = rv_pkg::imm_s;
                end
            end
            rv_pkg::opc_op_imm: begin
                ctl.reg_wen = 1'b1;
                case (funct3)
                    3'b000: ctl.alu_op = rv_pkg::alu_add;
                    3'b001: ctl.alu_op = rv_pkg::alu_sll;
                    3'b010: ctl.alu_op = rv_pkg::alu_slt;
                    3'b011: ctl.alu_op = rv_pkg::alu_sltu;
                    3'b100: ctl.alu_op = rv_pkg::alu_xor;
                    3'b101: ctl.alu_op = funct7_b30 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110: ctl.alu_op = rv_pkg::alu_or;
                    default: ctl.alu_op = rv_pkg::alu_and;
                endcase
            end
            default: ;
        endcase
    end

    // Kept apart from the control word, the flags depend on br_un
    always_comb begin
        pc_sel = 1'b0;
        case (opcode)
            rv_pkg::opc_jal:  pc_sel = 1'b1;
            rv_pkg::opc_jalr: pc_sel = (funct3 == 3'b000);
            rv_pkg::opc_branch: begin
                case (funct3)
                    3'b000:         pc_sel = br_eq;
                    3'b001:         pc_sel = !br_eq;
                    3'b100, 3'b110: pc_sel = br_lt;
                    3'b101, 3'b111: pc_sel = !br_lt;
                    default:        pc_sel = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        assert (!(ctl.mem_wr && ctl.reg_wen))
            else $error("instr_ctl: store decoded with register write");
    end

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_and    = 4'b0000,
        alu_or     = 4'b0001,
        alu_add    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_slt    = 4'b0100,
        alu_pass_b = 4'b0101,
        alu_sll    = 4'b0110,
        alu_srl    = 4'b0111,
        alu_xor    = 4'b1001,
        alu_sra    = 4'b1011
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i = 3'd1,
        imm_s = 3'd2,
        imm_b = 3'd3,
        imm_u = 3'd4,
        imm_j = 3'd5
    } imm_sel_e;

    typedef enum logic [1:0] {
        wb_mem = 2'd0,
        wb_alu = 2'd1,
        wb_pc4 = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic     a_sel;
        logic     b_sel;
        alu_op_e  alu_op;
        logic     mem_wr;
        logic     reg_wen;
        imm_sel_e imm_sel;
        logic     br_un;
        wb_sel_e  wb_sel;
    } ctl_t;

    // One entry per retired instruction
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic                  reg_wen;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wb_data;
    } retire_t;

endpackage

`default_nettype wire
